/* src.f */
+incdir+.
slc3Pkg.sv
isdu.sv
datapath.sv
mem2Io.sv
testMemory.sv
slc3.sv
slc3Tb.sv

/* slc3_golden.txt */
// Columns: switches, expected LED pause code, expected display word (all hex)
// One line per pause, three pauses per program loop
0001 005 0002
0001 009 0006
0001 00E FFFE
1234 005 2448
1234 009 1239
1234 00E EDCB
FFFB 005 0004
FFFB 009 0004
FFFB 00E 0004
A5A5 005 4A4A
A5A5 009 A5AA
A5A5 00E 5A5A
0000 005 0000
0000 009 0005
0000 00E FFFF
8000 005 0000
8000 009 8005
8000 00E 7FFF
7FFF 005 8000
7FFF 009 8004
7FFF 00E 8000
FFFF 005 0000
FFFF 009 0004
FFFF 00E 0000

/* slc3Tb.sv */
/*
  Testbench for the SLC-3 top level. Replays the golden steps. For each PAUSE
  it sets the switches, checks LED code and hex display, then presses and
  releases Continue.
*/
`timescale 1ns/10ps
`include "slc3_config.svh"

module slc3Tb;
    localparam int W = `SLC3_WORD_W;
    localparam int InDelay = 2;
    // Longer than any path from a resume to the next display write or pause
    localparam int QuietCycles = 48;

    logic Clk;
    logic rstN;
    logic Run;
    logic Continue;
    logic [W-1:0] Switches;
    logic [11:0] Led;
    logic [6:0] Hex0, Hex1, Hex2, Hex3;

    // Golden steps with one entry per pause
    logic [W-1:0] swQ[$];
    logic [11:0] ledQ[$];
    logic [W-1:0] dispQ[$];

    int cycles = 0;
    int cycleLimit = 0;
    logic [31:0] rngState;

    slc3 dut0 (.*);

    initial Clk = 1'b0;
    always #20 Clk = ~Clk;

    // Run limit armed once the golden file is read
    always @(posedge Clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------
    // Random hold lengths
    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int randomCycles();
        rngState = nextRandom(rngState);
        return int'(rngState % 4) + 1;
    endfunction

    // --------------------
    // Display model in active-low gfedcba order
    function automatic logic [6:0] segCode(input logic [3:0] nib);
        logic [6:0] table16 [16];
        table16 = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
        return table16[nib];
    endfunction

    // Unknown glyph decodes to X so the compare catches it
    function automatic logic [3:0] nibbleOf(input logic [6:0] code);
        nibbleOf = 4'bxxxx;
        for (int n = 0; n < 16; n++) begin
            if (segCode(4'(n)) === code) nibbleOf = 4'(n);
        end
    endfunction

    function automatic logic [W-1:0] displayWord();
        return {nibbleOf(Hex3), nibbleOf(Hex2), nibbleOf(Hex1), nibbleOf(Hex0)};
    endfunction

    // --------------------
    // Compare tasks
    task automatic checkWord(input logic [W-1:0] got, input logic [W-1:0] expected,
                             input string what);
        if (got !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkLed(input logic [11:0] got, input logic [11:0] expected,
                            input string what);
        if (got !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Sample and drive just after the rising edge
    task automatic nextCycle();
        @(posedge Clk);
        #InDelay;
    endtask

    // Nothing may change while the core sits in a pause
    task automatic holdPause(input int n, input logic [11:0] expLed,
                             input logic [W-1:0] expDisp);
        repeat (n) begin
            nextCycle();
            checkLed(Led, expLed, "LED during pause");
            checkWord(displayWord(), expDisp, "display during pause");
        end
    endtask

    task automatic readGolden();
        int fd;
        int got;
        string line;
        logic [W-1:0] sw;
        logic [W-1:0] disp;
        logic [11:0] led;
        fd = $fopen("slc3_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file slc3_golden.txt");
            $display("TEST FAILED");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            // Comment and blank lines do not scan as three fields
            if (got > 0 && $sscanf(line, "%h %h %h", sw, led, disp) == 3) begin
                swQ.push_back(sw);
                ledQ.push_back(led);
                dispQ.push_back(disp);
            end
        end
        $fclose(fd);
        if (swQ.size() == 0) begin
            $display("The golden file slc3_golden.txt holds no test steps");
            $display("TEST FAILED");
            $fatal(1, "empty stimulus file");
        end
    endtask

    // --------------------
    // Main sequence
    initial begin
        logic [11:0] prevLed;
        rstN = 1'b0;
        Run = 1'b0;
        Continue = 1'b0;
        Switches = '0;
        rngState = 33;
        readGolden();
        cycleLimit = swQ.size() * 200 + 100;
        Switches = swQ[0];

        repeat (4) @(posedge Clk);
        #InDelay;
        rstN = 1'b1;

        // Idle after reset and halted while Run is low
        checkLed(Led, 12'h000, "LED after reset");
        checkWord(displayWord(), 16'h0000, "display after reset");
        holdPause(QuietCycles, 12'h000, 16'h0000);

        Run = 1'b1;
        nextCycle();
        Run = 1'b0;

        prevLed = Led;
        for (int idx = 0; idx < swQ.size(); idx++) begin
            // LED loads on entry to the pause and the codes alternate every step
            while (Led === prevLed) nextCycle();
            checkLed(Led, ledQ[idx], "LED pause code");
            checkWord(displayWord(), dispQ[idx], "display word");
            holdPause(randomCycles(), ledQ[idx], dispQ[idx]);
            // New switch value is read by the next loop's LDR
            if (idx + 1 < swQ.size()) Switches = swQ[idx + 1];
            Continue = 1'b1;
            // Held long enough that a resume on press would show
            holdPause(QuietCycles + randomCycles(), ledQ[idx], dispQ[idx]);
            Continue = 1'b0;
            prevLed = Led;
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* slc3.sv */
/*
  SLC-3 top level. Ties the controller, datapath, memory/IO bridge and
  on-chip program memory together; board pins are the only ports.
*/
`timescale 1ns/10ps
`include "slc3_config.svh"

module slc3 (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    Run,
    input  logic                    Continue,
    input  logic [`SLC3_WORD_W-1:0] Switches,
    output logic [11:0]             Led,
    output logic [6:0]              Hex0,
    output logic [6:0]              Hex1,
    output logic [6:0]              Hex2,
    output logic [6:0]              Hex3
);
    import slc3Pkg::*;

    // Controller to datapath
    logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
    logic gatePc, gateMdr, gateAlu, gateMarmux;
    logic [1:0] pcMux;
    logic [1:0] addr2Mux;
    logic addr1Mux, sr2Mux, drMux;
    aluFuncT aluK;
    logic memOe, memWe;

    // Datapath to controller and bridge
    logic [`SLC3_WORD_W-1:0] ir, mar, mdr, dataToCpu;
    logic ben;

    // Bridge to memory
    logic [`SLC3_MEM_ADDR_W-1:0] memAddr;
    logic [`SLC3_WORD_W-1:0] memWrData, memRdData;
    logic memWeOut;

    isdu ctrl0 (.*);

    datapath dp0 (.*);

    mem2Io bridge0 (
        .Clk, .rstN, .Switches, .mar, .mdr, .memOe, .memWe, .memRdData,
        .dataToCpu, .memAddr, .memWrData, .memWeOut, .Hex0, .Hex1, .Hex2, .Hex3
    );

    testMemory mem0 (
        .Clk, .memAddr, .memWrData, .memWe(memWeOut), .memRdData
    );

endmodule

/* testMemory.sv */
/*
  On-chip word memory with registered read data, preloaded with the
  demonstration program. Address bits above the depth are ignored.
*/
`timescale 1ns/10ps
`include "slc3_config.svh"

module testMemory (
    input  logic                        Clk,
    input  logic [`SLC3_MEM_ADDR_W-1:0] memAddr,
    input  logic [`SLC3_WORD_W-1:0]     memWrData,
    input  logic                        memWe,
    output logic [`SLC3_WORD_W-1:0]     memRdData
);
    logic [`SLC3_WORD_W-1:0] mem [`SLC3_MEM_DEPTH];

    // --------------------
    // Demonstration program, data area is zero
    initial begin
        for (int i = 0; i < `SLC3_MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
        mem[0]  = 16'h623F;  // LDR R1, R0, #-1   switches
        mem[1]  = 16'h1441;  // ADD R2, R1, R1
        mem[2]  = 16'h967F;  // NOT R3, R1
        mem[3]  = 16'h5883;  // AND R4, R2, R3
        mem[4]  = 16'h783F;  // STR R4, R0, #-1   display
        mem[5]  = 16'hD005;  // PAUSE x005
        mem[6]  = 16'h1A65;  // ADD R5, R1, #5
        mem[7]  = 16'h0401;  // BRz #1
        mem[8]  = 16'h7A3F;  // STR R5, R0, #-1
        mem[9]  = 16'hD009;  // PAUSE x009
        // 0xFFE0 aliases to word 32
        mem[10] = 16'h7220;  // STR R1, R0, #-32
        mem[11] = 16'h6C20;  // LDR R6, R0, #-32
        mem[12] = 16'h9DBF;  // NOT R6, R6
        mem[13] = 16'h7C3F;  // STR R6, R0, #-1
        mem[14] = 16'hD00E;  // PAUSE x00E
        mem[15] = 16'h0FF0;  // BRnzp #-16
    end

    // Write first, read data one cycle after the address
    always_ff @(posedge Clk) begin
        if (memWe) begin
            mem[memAddr] <= memWrData;
        end
        memRdData <= mem[memAddr];
    end

endmodule

/* mem2Io.sv */
/*
  Memory/IO bridge. Address 0xFFFF reads the switches and writes the hex
  display latch; all other addresses go to the on-chip memory.
*/
`timescale 1ns/10ps
`include "slc3_config.svh"

module mem2Io (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic [`SLC3_WORD_W-1:0]     Switches,
    input  logic [`SLC3_WORD_W-1:0]     mar,
    input  logic [`SLC3_WORD_W-1:0]     mdr,
    input  logic                        memOe,
    input  logic                        memWe,
    input  logic [`SLC3_WORD_W-1:0]     memRdData,
    output logic [`SLC3_WORD_W-1:0]     dataToCpu,
    output logic [`SLC3_MEM_ADDR_W-1:0] memAddr,
    output logic [`SLC3_WORD_W-1:0]     memWrData,
    output logic                        memWeOut,
    output logic [6:0]                  Hex0,
    output logic [6:0]                  Hex1,
    output logic [6:0]                  Hex2,
    output logic [6:0]                  Hex3
);
    logic isIo;
    logic [`SLC3_WORD_W-1:0] hexLatch;

    // Active-low segments, bit order gfedcba
    function automatic logic [6:0] segOf(input logic [3:0] nib);
        case (nib)
            4'h0: segOf = 7'b1000000;
            4'h1: segOf = 7'b1111001;
            4'h2: segOf = 7'b0100100;
            4'h3: segOf = 7'b0110000;
            4'h4: segOf = 7'b0011001;
            4'h5: segOf = 7'b0010010;
            4'h6: segOf = 7'b0000010;
            4'h7: segOf = 7'b1111000;
            4'h8: segOf = 7'b0000000;
            4'h9: segOf = 7'b0010000;
            4'hA: segOf = 7'b0001000;
            4'hB: segOf = 7'b0000011;
            4'hC: segOf = 7'b1000110;
            4'hD: segOf = 7'b0100001;
            4'hE: segOf = 7'b0000110;
            default: segOf = 7'b0001110;
        endcase
    endfunction

    assign isIo = (mar == `SLC3_IO_ADDR);

    // Read mux, idle bus reads as zero
    assign dataToCpu = !memOe ? '0 : isIo ? Switches : memRdData;

    // Memory only sees the low address bits; IO writes never reach it
    assign memAddr   = mar[`SLC3_MEM_ADDR_W-1:0];
    assign memWrData = mdr;
    assign memWeOut  = memWe && !isIo;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            hexLatch <= '0;
        end else if (memWe && isIo) begin
            hexLatch <= mdr;
        end
    end

    // Hex3 is the most significant digit
    assign Hex0 = segOf(hexLatch[3:0]);
    assign Hex1 = segOf(hexLatch[7:4]);
    assign Hex2 = segOf(hexLatch[11:8]);
    assign Hex3 = segOf(hexLatch[15:12]);

endmodule

/* datapath.sv */
/*
  SLC-3 datapath. Register file, PC, IR, MAR, MDR, nzp flags and LED
  register share one gated bus; ALU and address adder feed that bus.
*/
`timescale 1ns/10ps
`include "slc3_config.svh"

module datapath (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    ldMar,
    input  logic                    ldMdr,
    input  logic                    ldIr,
    input  logic                    ldBen,
    input  logic                    ldCc,
    input  logic                    ldReg,
    input  logic                    ldPc,
    input  logic                    ldLed,
    input  logic                    gatePc,
    input  logic                    gateMdr,
    input  logic                    gateAlu,
    input  logic                    gateMarmux,
    input  logic [1:0]              pcMux,
    input  logic                    addr1Mux,
    input  logic [1:0]              addr2Mux,
    input  logic                    sr2Mux,
    input  logic                    drMux,
    input  slc3Pkg::aluFuncT        aluK,
    input  logic                    memOe,
    input  logic [`SLC3_WORD_W-1:0] dataToCpu,
    output logic [`SLC3_WORD_W-1:0] ir,
    output logic                    ben,
    output logic [`SLC3_WORD_W-1:0] mar,
    output logic [`SLC3_WORD_W-1:0] mdr,
    output logic [11:0]             Led
);
    import slc3Pkg::*;

    localparam int W = `SLC3_WORD_W;
    localparam int RegIdxW = $clog2(`SLC3_REG_COUNT);

    logic [W-1:0] regFile [`SLC3_REG_COUNT];
    logic [W-1:0] pc, bus, mdrGate;
    logic [W-1:0] aluA, aluB, aluOut;
    logic [W-1:0] addr1, addr2, addrSum;
    logic [RegIdxW-1:0] sr1, sr2, dr;
    logic [2:0] nzp;
    opcodeT opcode;

    // --------------------
    // Register selects from IR
    assign opcode = opcodeT'(ir[15:12]);
    assign sr1    = ir[8:6];
    // STR reads its source register through the second read port
    assign sr2    = (opcode == opStr) ? ir[11:9] : ir[2:0];
    // drMux set targets R7
    assign dr     = drMux ? {RegIdxW{1'b1}} : ir[11:9];

    // ALU, operand B is register or sign-extended imm5
    assign aluA = regFile[sr1];
    assign aluB = sr2Mux ? {{(W-5){ir[4]}}, ir[4:0]} : regFile[sr2];

    always_comb begin
        case (aluK)
            aluAdd:  aluOut = aluA + aluB;
            aluAnd:  aluOut = aluA & aluB;
            aluNot:  aluOut = ~aluA;
            default: aluOut = aluB;
        endcase
    end

    // Address adder, base is PC or BaseR
    assign addr1 = addr1Mux ? aluA : pc;
    always_comb begin
        case (addr2Mux)
            2'd0:    addr2 = '0;
            2'd1:    addr2 = {{(W-6){ir[5]}}, ir[5:0]};
            2'd2:    addr2 = {{(W-9){ir[8]}}, ir[8:0]};
            default: addr2 = {{(W-11){ir[10]}}, ir[10:0]};
        endcase
    end
    assign addrSum = addr1 + addr2;

    // --------------------
    // Bus; MDR gate forwards read data in the cycle MDR loads it
    assign mdrGate = memOe ? dataToCpu : mdr;
    always_comb begin
        bus = '0;
        if (gatePc) bus = pc;
        else if (gateMdr) bus = mdrGate;
        else if (gateAlu) bus = aluOut;
        else if (gateMarmux) bus = addrSum;
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc  <= '0;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            nzp <= 3'b010;
            ben <= 1'b0;
            Led <= '0;
        end else begin
            if (ldPc) begin
                case (pcMux)
                    2'd0:    pc <= pc + 1'b1;
                    2'd1:    pc <= bus;
                    default: pc <= addrSum;
                endcase
            end
            if (ldIr) ir <= bus;
            if (ldMar) mar <= bus;
            if (ldMdr) mdr <= memOe ? dataToCpu : bus;
            // Flags follow whatever is on the bus
            if (ldCc) nzp <= {bus[W-1], bus == '0, !bus[W-1] && bus != '0};
            if (ldBen) ben <= |(ir[11:9] & nzp);
            // PAUSE code
            if (ldLed) Led <= ir[11:0];
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `SLC3_REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (ldReg) begin
            regFile[dr] <= bus;
        end
    end

    // Bus contention between the four gated sources
    assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({gatePc, gateMdr, gateAlu, gateMarmux}));

endmodule

/* isdu.sv */
/*
  Control FSM for the SLC-3. Sequences fetch, decode and per-opcode execute
  states and drives all loads, bus gates, mux selects and memory strobes.
*/
`timescale 1ns/10ps
`include "slc3_config.svh"

module isdu (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    Run,
    input  logic                    Continue,
    input  logic [`SLC3_WORD_W-1:0] ir,
    input  logic                    ben,
    output logic                    ldMar,
    output logic                    ldMdr,
    output logic                    ldIr,
    output logic                    ldBen,
    output logic                    ldCc,
    output logic                    ldReg,
    output logic                    ldPc,
    output logic                    ldLed,
    output logic                    gatePc,
    output logic                    gateMdr,
    output logic                    gateAlu,
    output logic                    gateMarmux,
    output logic [1:0]              pcMux,
    output logic                    addr1Mux,
    output logic [1:0]              addr2Mux,
    output logic                    sr2Mux,
    output logic                    drMux,
    output slc3Pkg::aluFuncT        aluK,
    output logic                    memOe,
    output logic                    memWe
);
    import slc3Pkg::*;

    stateT  state;
    stateT  nextState;
    opcodeT opcode;

    assign opcode = opcodeT'(ir[15:12]);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= sHalted;
        end else begin
            state <= nextState;
        end
    end

    // --------------------
    // Next state
    always_comb begin
        nextState = sFetch1;
        case (state)
            sHalted:  nextState = Run ? sFetch1 : sHalted;
            sFetch1:  nextState = sFetch2;
            sFetch2:  nextState = sFetch3;
            sFetch3:  nextState = sDecode;
            sDecode: begin
                case (opcode)
                    opAdd:   nextState = sAdd;
                    opAnd:   nextState = sAnd;
                    opNot:   nextState = sNot;
                    opBr:    nextState = sBr;
                    opLdr:   nextState = sLdr1;
                    opStr:   nextState = sStr1;
                    opPause: nextState = sPause1;
                    // Unsupported opcode is skipped
                    default: nextState = sFetch1;
                endcase
            end
            sBr:      nextState = ben ? sBrTaken : sFetch1;
            sLdr1:    nextState = sLdr2;
            sLdr2:    nextState = sLdr3;
            sLdr3:    nextState = sLdr4;
            sStr1:    nextState = sStr2;
            sStr2:    nextState = sStr3;
            // Hold until Continue is pressed, then until released
            sPause1:  nextState = Continue ? sPause2 : sPause1;
            sPause2:  nextState = Continue ? sPause2 : sFetch1;
            default:  nextState = sFetch1;
        endcase
    end

    // --------------------
    // Control outputs default to idle
    always_comb begin
        {ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed} = '0;
        {gatePc, gateMdr, gateAlu, gateMarmux} = '0;
        {memOe, memWe} = '0;
        pcMux    = 2'd0;
        addr1Mux = 1'b0;
        addr2Mux = 2'd0;
        sr2Mux   = 1'b0;
        drMux    = 1'b0;
        aluK     = aluPass;
        case (state)
            // MAR <- PC, PC <- PC + 1, read starts
            sFetch1: {gatePc, ldMar, ldPc, memOe} = '1;
            sFetch2: memOe = 1'b1;
            // Read data lands in MDR and IR together
            sFetch3: {memOe, ldMdr, gateMdr, ldIr} = '1;
            // Latch BEN; stage the STR source register in MDR
            sDecode: {ldBen, gateAlu, ldMdr} = '1;
            sAdd, sAnd, sNot: begin
                {gateAlu, ldReg, ldCc} = '1;
                aluK   = (state == sAdd) ? aluAdd : (state == sAnd) ? aluAnd : aluNot;
                // IR[5] picks the imm5 form
                sr2Mux = ir[5];
            end
            // PC <- PC + PCoffset9
            sBrTaken: begin
                ldPc     = 1'b1;
                pcMux    = 2'd2;
                addr2Mux = 2'd2;
            end
            // MAR <- BaseR + offset6
            sLdr1, sStr1: begin
                {gateMarmux, ldMar} = '1;
                addr1Mux = 1'b1;
                addr2Mux = 2'd1;
            end
            sLdr2, sLdr3: memOe = 1'b1;
            sLdr4: {memOe, ldMdr, gateMdr, ldReg, ldCc} = '1;
            sStr2, sStr3: memWe = 1'b1;
            sPause1: ldLed = 1'b1;
            default: ;
        endcase
    end

    // The bridge and memory rely on one strobe at a time
    assert property (@(posedge Clk) disable iff (!rstN) !(memOe && memWe));
    // Only one source may drive the datapath bus
    assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({gatePc, gateMdr, gateAlu, gateMarmux}));

endmodule

/* slc3Pkg.sv */
/*
  Shared enums for the SLC-3 core: opcodes, controller states and ALU
  functions. Import into the module body where the types are used.
*/
package slc3Pkg;

    // LC-3 opcode field IR[15:12], supported subset only
    typedef enum logic [3:0] {
        opBr    = 4'b0000,
        opAdd   = 4'b0001,
        opAnd   = 4'b0101,
        opLdr   = 4'b0110,
        opStr   = 4'b0111,
        opNot   = 4'b1001,
        opPause = 4'b1101
    } opcodeT;

    // Controller states
    typedef enum logic [4:0] {
        sHalted, sFetch1, sFetch2, sFetch3, sDecode,
        sAdd, sAnd, sNot, sBr, sBrTaken,
        sLdr1, sLdr2, sLdr3, sLdr4,
        sStr1, sStr2, sStr3,
        sPause1, sPause2
    } stateT;

    // ALU function select, aluPass forwards operand B
    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPass} aluFuncT;

endpackage

/* slc3_config.svh */
/*
  Build-wide constants for the SLC-3 core. Covers the word and memory widths,
  register count, memory depth and the memory-mapped IO address.
  Include this in any file that sizes ports or memories.
*/
`ifndef SLC3_CONFIG_SVH
`define SLC3_CONFIG_SVH

// Data word, also the width of every CPU register
`define SLC3_WORD_W 16
// Word address into the on-chip memory
`define SLC3_MEM_ADDR_W 6
`define SLC3_MEM_DEPTH 64
// General-purpose registers R0..R7
`define SLC3_REG_COUNT 8
// Switches on read, hex display latch on write
`define SLC3_IO_ADDR 16'hFFFF

`endif
